// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_core_mem
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^TB PASSED$$"

clean:
	rm -rf $(BUILD_DIR)

// ==== files.f ====
+incdir+rtl
rtl/core_mem_pkg.sv
rtl/lsu_req_decode.sv
rtl/dcache_direct.sv
rtl/mem_arbiter.sv
rtl/load_align.sv
rtl/core_mem_top.sv
verification/core_mem_sva.sv
verification/tb_core_mem.sv

// ==== rtl/core_mem_params.svh ====
`ifndef CORE_MEM_PARAMS_SVH
`define CORE_MEM_PARAMS_SVH

// ********************************************************************
// data path widths
// ********************************************************************
`define CM_XLEN     64
`define CM_AW       32
`define CM_STRB     8

// ********************************************************************
// data cache geometry
// ********************************************************************
// one 64-bit word per line
`define CM_LINES    16
`define CM_IDX_W    4

// ********************************************************************
// cacheable window, upper bound exclusive
// ********************************************************************
`define CM_CACHE_LO 32'h8000_0000
`define CM_CACHE_HI 32'h8800_0000

`endif

// ==== rtl/core_mem_pkg.sv ====
`default_nettype none

`include "core_mem_params.svh"

package core_mem_pkg;

    // access width of a load or store
    typedef enum logic [1:0] {
        MW_BYTE   = 2'd0,
        MW_HALF   = 2'd1,
        MW_WORD   = 2'd2,
        MW_DOUBLE = 2'd3
    } mem_width_e;

    // request from the load/store unit
    typedef struct packed {
        logic                valid;
        logic                we;
        logic [`CM_AW-1:0]   addr;
        logic [`CM_XLEN-1:0] wdata;
        mem_width_e          width;
        logic                sign;
    } lsu_req_t;

    typedef struct packed {
        logic                valid;
        logic                is_write;
        logic [`CM_XLEN-1:0] rdata;
    } lsu_rsp_t;

    // registered request as the cache sees it, wdata already replicated
    typedef struct packed {
        lsu_req_t            req;
        logic                uncached;
        logic [`CM_STRB-1:0] strb;
    } cache_req_t;

    typedef struct packed {
        logic              valid;
        logic [`CM_AW-1:0] addr;
    } fetch_req_t;

    typedef struct packed {
        logic                valid;
        logic [`CM_XLEN-1:0] data;
    } fetch_rsp_t;

    // memory bus, addr is always 8-byte aligned
    typedef struct packed {
        logic                valid;
        logic                we;
        logic [`CM_AW-1:0]   addr;
        logic [`CM_XLEN-1:0] wdata;
        logic [`CM_STRB-1:0] strb;
    } mem_req_t;

    typedef struct packed {
        logic                valid;
        logic [`CM_XLEN-1:0] rdata;
    } mem_rsp_t;

endpackage

`default_nettype wire

// ==== rtl/core_mem_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "core_mem_params.svh"

module core_mem_top import core_mem_pkg::*; (
    input  logic       clk,
    input  logic       rst_n_i,
    input  lsu_req_t   lsu_req_i,
    output logic       lsu_ready_o,
    output lsu_rsp_t   lsu_rsp_o,
    input  fetch_req_t fetch_req_i,
    output logic       fetch_ready_o,
    output fetch_rsp_t fetch_rsp_o,
    output mem_req_t   mem_req_o,
    input  logic       mem_ready_i,
    input  mem_rsp_t   mem_rsp_i
);

    cache_req_t          dec_req;
    cache_req_t          held_req;
    mem_req_t            data_mem_req;
    mem_rsp_t            data_mem_rsp;
    logic                data_gnt;
    logic                word_valid;
    logic [`CM_XLEN-1:0] word;

    // ********************************************************************
    // data side
    // ********************************************************************
    lsu_req_decode u_decode (
        .clk         ( clk             ),
        .rst_n_i     ( rst_n_i         ),
        .lsu_req_i   ( lsu_req_i       ),
        .lsu_ready_o ( lsu_ready_o     ),
        .rsp_done_i  ( lsu_rsp_o.valid ),
        .req_o       ( dec_req         )
    );

    dcache_direct u_dcache (
        .clk          ( clk          ),
        .rst_n_i      ( rst_n_i      ),
        .req_i        ( dec_req      ),
        .mem_req_o    ( data_mem_req ),
        .mem_gnt_i    ( data_gnt     ),
        .mem_rsp_i    ( data_mem_rsp ),
        .word_valid_o ( word_valid   ),
        .word_o       ( word         ),
        .req_held_o   ( held_req     )
    );

    load_align u_align (
        .word_valid_i ( word_valid ),
        .word_i       ( word       ),
        .req_i        ( held_req   ),
        .lsu_rsp_o    ( lsu_rsp_o  )
    );

    // ********************************************************************
    // fetch and data onto the one bus
    // ********************************************************************
    mem_arbiter u_arbiter (
        .clk           ( clk           ),
        .rst_n_i       ( rst_n_i       ),
        .fetch_req_i   ( fetch_req_i   ),
        .fetch_ready_o ( fetch_ready_o ),
        .fetch_rsp_o   ( fetch_rsp_o   ),
        .data_req_i    ( data_mem_req  ),
        .data_gnt_o    ( data_gnt      ),
        .data_rsp_o    ( data_mem_rsp  ),
        .mem_req_o     ( mem_req_o     ),
        .mem_ready_i   ( mem_ready_i   ),
        .mem_rsp_i     ( mem_rsp_i     )
    );

endmodule

`default_nettype wire

// ==== rtl/dcache_direct.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "core_mem_params.svh"

module dcache_direct import core_mem_pkg::*; (
    input  logic                clk,
    input  logic                rst_n_i,
    input  cache_req_t          req_i,
    output mem_req_t            mem_req_o,
    input  logic                mem_gnt_i,
    input  mem_rsp_t            mem_rsp_i,
    output logic                word_valid_o,
    output logic [`CM_XLEN-1:0] word_o,
    output cache_req_t          req_held_o
);

    localparam int OFF_W = $clog2(`CM_STRB);
    localparam int TAG_W = `CM_AW - OFF_W - `CM_IDX_W;

    typedef enum logic [1:0] {
        S_IDLE,
        S_LOOK,
        S_REQ,
        S_WAIT
    } state_e;

    state_e               state_q;
    cache_req_t           held_q;
    logic [`CM_LINES-1:0] line_vld_q;
    logic [TAG_W-1:0]     tag_q  [`CM_LINES];
    logic [`CM_XLEN-1:0]  data_q [`CM_LINES];

    logic [`CM_IDX_W-1:0] idx;
    logic [TAG_W-1:0]     tag;
    logic                 hit;
    logic                 load_hit;
    logic                 store_hit;
    logic                 fill;

    assign idx       = held_q.req.addr[OFF_W +: `CM_IDX_W];
    assign tag       = held_q.req.addr[`CM_AW-1 -: TAG_W];
    assign hit       = !held_q.uncached && line_vld_q[idx] && (tag_q[idx] == tag);
    assign load_hit  = (state_q == S_LOOK) && hit && !held_q.req.we;
    assign store_hit = (state_q == S_LOOK) && hit && held_q.req.we;
    // only cacheable loads allocate
    assign fill      = (state_q == S_WAIT) && mem_rsp_i.valid &&
                       !held_q.req.we && !held_q.uncached;

    // ********************************************************************
    // control
    // ********************************************************************
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q    <= S_IDLE;
            line_vld_q <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (req_i.req.valid) begin
                        state_q <= S_LOOK;
                    end
                end
                S_LOOK: begin
                    state_q <= load_hit ? S_IDLE : S_REQ;
                end
                S_REQ: begin
                    if (mem_gnt_i) begin
                        state_q <= S_WAIT;
                    end
                end
                default: begin
                    if (mem_rsp_i.valid) begin
                        state_q <= S_IDLE;
                    end
                end
            endcase
            if (fill) begin
                line_vld_q[idx] <= 1'b1;
            end
        end
    end

    // ********************************************************************
    // request hold, tag and data arrays
    // ********************************************************************
    always_ff @(posedge clk) begin
        if ((state_q == S_IDLE) && req_i.req.valid) begin
            held_q <= req_i;
        end
        if (fill) begin
            tag_q[idx]  <= tag;
            data_q[idx] <= mem_rsp_i.rdata;
        end
        // write-through, keep the cached copy in step
        if (store_hit) begin
            for (int b = 0; b < `CM_STRB; b++) begin
                if (held_q.strb[b]) begin
                    data_q[idx][8*b +: 8] <= held_q.req.wdata[8*b +: 8];
                end
            end
        end
    end

    always_comb begin
        mem_req_o.valid = (state_q == S_REQ);
        mem_req_o.we    = held_q.req.we;
        mem_req_o.addr  = {held_q.req.addr[`CM_AW-1:OFF_W], {OFF_W{1'b0}}};
        mem_req_o.wdata = held_q.req.wdata;
        mem_req_o.strb  = held_q.req.we ? held_q.strb : '0;
    end

    // hits answer from the array, everything else from the bus
    assign word_valid_o = load_hit || ((state_q == S_WAIT) && mem_rsp_i.valid);
    assign word_o       = (state_q == S_WAIT) ? mem_rsp_i.rdata : data_q[idx];
    assign req_held_o   = held_q;

endmodule

`default_nettype wire

// ==== rtl/load_align.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "core_mem_params.svh"

module load_align import core_mem_pkg::*; (
    input  logic                word_valid_i,
    input  logic [`CM_XLEN-1:0] word_i,
    input  cache_req_t          req_i,
    output lsu_rsp_t            lsu_rsp_o
);

    localparam int OFF_W = $clog2(`CM_STRB);

    logic [OFF_W-1:0]    offs;
    logic [`CM_XLEN-1:0] shifted;
    logic [`CM_XLEN-1:0] ext;

    assign offs    = req_i.req.addr[OFF_W-1:0];
    // byte offset to bit shift
    assign shifted = word_i >> {offs, 3'b000};

    always_comb begin
        case (req_i.req.width)
            MW_BYTE: begin
                ext = {{(`CM_XLEN-8){req_i.req.sign & shifted[7]}}, shifted[7:0]};
            end
            MW_HALF: begin
                ext = {{(`CM_XLEN-16){req_i.req.sign & shifted[15]}}, shifted[15:0]};
            end
            MW_WORD: begin
                ext = {{(`CM_XLEN-32){req_i.req.sign & shifted[31]}}, shifted[31:0]};
            end
            default: begin
                ext = shifted;
            end
        endcase
    end

    // stores only acknowledge
    assign lsu_rsp_o.valid    = word_valid_i;
    assign lsu_rsp_o.is_write = req_i.req.we;
    assign lsu_rsp_o.rdata    = req_i.req.we ? '0 : ext;

endmodule

`default_nettype wire

// ==== rtl/lsu_req_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "core_mem_params.svh"

module lsu_req_decode import core_mem_pkg::*; (
    input  logic       clk,
    input  logic       rst_n_i,
    input  lsu_req_t   lsu_req_i,
    output logic       lsu_ready_o,
    input  logic       rsp_done_i,
    output cache_req_t req_o
);

    localparam int OFF_W = $clog2(`CM_STRB);

    logic                in_flight_q;
    logic                req_vld_q;
    cache_req_t          req_q;
    logic                accept;
    logic [`CM_STRB-1:0] base_strb;
    logic [`CM_XLEN-1:0] rep_data;
    logic [OFF_W-1:0]    offs;

    assign lsu_ready_o = !in_flight_q;
    assign accept      = lsu_req_i.valid && lsu_ready_o;
    assign offs        = lsu_req_i.addr[OFF_W-1:0];

    // lane mask and store data copied into every lane
    always_comb begin
        case (lsu_req_i.width)
            MW_BYTE: begin
                base_strb = 8'h01;
                rep_data  = {8{lsu_req_i.wdata[7:0]}};
            end
            MW_HALF: begin
                base_strb = 8'h03;
                rep_data  = {4{lsu_req_i.wdata[15:0]}};
            end
            MW_WORD: begin
                base_strb = 8'h0f;
                rep_data  = {2{lsu_req_i.wdata[31:0]}};
            end
            default: begin
                base_strb = 8'hff;
                rep_data  = lsu_req_i.wdata;
            end
        endcase
    end

    // one request in flight, cleared by its response
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            in_flight_q <= 1'b0;
            req_vld_q   <= 1'b0;
        end else begin
            req_vld_q <= accept;
            if (accept) begin
                in_flight_q <= 1'b1;
            end else if (rsp_done_i) begin
                in_flight_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q.req       <= lsu_req_i;
            req_q.req.wdata <= rep_data;
            // outside the window means bypass
            req_q.uncached  <= (lsu_req_i.addr < `CM_CACHE_LO) ||
                               (lsu_req_i.addr >= `CM_CACHE_HI);
            req_q.strb      <= base_strb << offs;
        end
    end

    always_comb begin
        req_o           = req_q;
        req_o.req.valid = req_vld_q;
    end

endmodule

`default_nettype wire

// ==== rtl/mem_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "core_mem_params.svh"

module mem_arbiter import core_mem_pkg::*; (
    input  logic       clk,
    input  logic       rst_n_i,
    input  fetch_req_t fetch_req_i,
    output logic       fetch_ready_o,
    output fetch_rsp_t fetch_rsp_o,
    input  mem_req_t   data_req_i,
    output logic       data_gnt_o,
    output mem_rsp_t   data_rsp_o,
    output mem_req_t   mem_req_o,
    input  logic       mem_ready_i,
    input  mem_rsp_t   mem_rsp_i
);

    localparam int OFF_W = $clog2(`CM_STRB);

    typedef enum logic [1:0] {
        OWN_IDLE,
        OWN_FETCH,
        OWN_DATA
    } owner_e;

    owner_e            owner_q;
    logic              issued_q;
    logic              fetch_busy_q;
    logic              fetch_pend_q;
    logic [`CM_AW-1:0] fetch_addr_q;
    logic              fetch_acc;
    logic              bus_req;

    assign fetch_ready_o = !fetch_busy_q;
    assign fetch_acc     = fetch_req_i.valid && fetch_ready_o;
    // owner is picked one cycle ahead so the bus never switches mid-wait
    assign bus_req       = (owner_q != OWN_IDLE) && !issued_q;

    always_comb begin
        mem_req_o = '0;
        if (bus_req && (owner_q == OWN_DATA)) begin
            mem_req_o       = data_req_i;
            mem_req_o.valid = 1'b1;
        end else if (bus_req) begin
            mem_req_o.valid = 1'b1;
            mem_req_o.addr  = {fetch_addr_q[`CM_AW-1:OFF_W], {OFF_W{1'b0}}};
        end
    end

    assign data_gnt_o = bus_req && (owner_q == OWN_DATA) && mem_ready_i;

    // route the response back to whoever issued it
    assign data_rsp_o.valid  = issued_q && (owner_q == OWN_DATA) && mem_rsp_i.valid;
    assign data_rsp_o.rdata  = mem_rsp_i.rdata;
    assign fetch_rsp_o.valid = issued_q && (owner_q == OWN_FETCH) && mem_rsp_i.valid;
    assign fetch_rsp_o.data  = mem_rsp_i.rdata;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            owner_q      <= OWN_IDLE;
            issued_q     <= 1'b0;
            fetch_busy_q <= 1'b0;
            fetch_pend_q <= 1'b0;
        end else begin
            if (fetch_acc) begin
                fetch_busy_q <= 1'b1;
                fetch_pend_q <= 1'b1;
            end else if (fetch_rsp_o.valid) begin
                fetch_busy_q <= 1'b0;
            end
            case (owner_q)
                OWN_IDLE: begin
                    // data side first
                    if (data_req_i.valid) begin
                        owner_q <= OWN_DATA;
                    end else if (fetch_pend_q) begin
                        owner_q      <= OWN_FETCH;
                        fetch_pend_q <= 1'b0;
                    end
                end
                default: begin
                    if (!issued_q && mem_ready_i) begin
                        issued_q <= 1'b1;
                    end else if (issued_q && mem_rsp_i.valid) begin
                        issued_q <= 1'b0;
                        owner_q  <= OWN_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_acc) begin
            fetch_addr_q <= fetch_req_i.addr;
        end
    end

endmodule

`default_nettype wire

// ==== verification/core_mem_sva.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "core_mem_params.svh"

module core_mem_sva import core_mem_pkg::*; (
    input logic       clk,
    input logic       rst_n_i,
    input lsu_req_t   lsu_req_i,
    input logic       lsu_ready_o,
    input lsu_rsp_t   lsu_rsp_o,
    input fetch_rsp_t fetch_rsp_o,
    input mem_req_t   mem_req_o,
    input logic       mem_ready_i,
    input mem_rsp_t   mem_rsp_i
);

    logic bus_busy_q;
    logic lsu_busy_q;

    // outstanding bus transfer and data request in flight
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bus_busy_q <= 1'b0;
            lsu_busy_q <= 1'b0;
        end else begin
            if (mem_req_o.valid && mem_ready_i) begin
                bus_busy_q <= 1'b1;
            end else if (mem_rsp_i.valid) begin
                bus_busy_q <= 1'b0;
            end
            if (lsu_req_i.valid && lsu_ready_o) begin
                lsu_busy_q <= 1'b1;
            end else if (lsu_rsp_o.valid) begin
                lsu_busy_q <= 1'b0;
            end
        end
    end

    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_req_o.valid && !mem_ready_i |=> $stable(mem_req_o))
        else $error("memory request changed while waiting for ready");

    a_one_outstanding: assert property (@(posedge clk) disable iff (!rst_n_i)
        bus_busy_q |-> !(mem_req_o.valid && mem_ready_i))
        else $error("second bus transfer while one is outstanding");

    a_lsu_ready_low: assert property (@(posedge clk) disable iff (!rst_n_i)
        lsu_busy_q |-> !lsu_ready_o)
        else $error("lsu ready high with a request in flight");

    a_reset_quiet: assert property (@(posedge clk)
        !rst_n_i |-> !lsu_rsp_o.valid && !fetch_rsp_o.valid && !mem_req_o.valid)
        else $error("valid output high during reset");

endmodule

bind core_mem_top core_mem_sva u_sva (
    .clk         ( clk         ),
    .rst_n_i     ( rst_n_i     ),
    .lsu_req_i   ( lsu_req_i   ),
    .lsu_ready_o ( lsu_ready_o ),
    .lsu_rsp_o   ( lsu_rsp_o   ),
    .fetch_rsp_o ( fetch_rsp_o ),
    .mem_req_o   ( mem_req_o   ),
    .mem_ready_i ( mem_ready_i ),
    .mem_rsp_i   ( mem_rsp_i   )
);

`default_nettype wire

// ==== verification/tb_core_mem.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "core_mem_params.svh"

module tb_core_mem import core_mem_pkg::*; ();

    localparam int N_OPS     = 24 + 32 + 80 + 80;
    localparam int OP_CYCLES = 60;

    logic       clk;
    logic       rst_n_i;
    lsu_req_t   lsu_req_i;
    logic       lsu_ready_o;
    lsu_rsp_t   lsu_rsp_o;
    fetch_req_t fetch_req_i;
    logic       fetch_ready_o;
    fetch_rsp_t fetch_rsp_o;
    mem_req_t   mem_req_o;
    logic       mem_ready_i;
    mem_rsp_t   mem_rsp_i;

    logic [63:0] mem    [logic [31:0]];
    logic [63:0] shadow [logic [31:0]];
    int       checks;
    int       errors;
    int       bus_rd;
    int       bus_wr;
    int       lsu_seen;
    int       fetch_seen;
    int       lsu_ops;
    int       fetch_ops;
    mem_req_t last_wr;
    mem_req_t cur;
    logic     outstanding;
    int       delay;

    core_mem_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #(N_OPS * OP_CYCLES * 20 + 2000);
        $display("watchdog expired before all tests finished");
        $display("TB FAILED");
        $finish;
    end

    function automatic logic [63:0] fill_word(input logic [31:0] a);
        return {a ^ 32'h5a5a_a5a5, ~a};
    endfunction

    function automatic logic [63:0] shadow_word(input logic [31:0] a);
        return shadow.exists(a) ? shadow[a] : fill_word(a);
    endfunction

    function automatic logic [63:0] extend(input logic [63:0] v, input int nb, input logic sgn);
        logic [63:0] m;
        if (nb == 8) begin
            return v;
        end
        m = (64'd1 << (8 * nb)) - 64'd1;
        v = v & m;
        if (sgn && v[8*nb-1]) begin
            v = v | ~m;
        end
        return v;
    endfunction

    // random address aligned to the access width
    function automatic logic [31:0] rand_addr(input logic [31:0] base, input int words,
                                              input int nb);
        return base + ($urandom % words) * 8 + (($urandom % 8) & ~(nb - 1));
    endfunction

    // ********************************************************************
    // memory model, one transfer outstanding
    // ********************************************************************
    always @(negedge clk) begin
        logic        rdy;
        logic [31:0] a;
        logic [63:0] w;
        mem_rsp_i <= '0;
        if (outstanding) begin
            delay--;
            if (delay == 0) begin
                outstanding = 1'b0;
                a = cur.addr;
                w = mem.exists(a) ? mem[a] : fill_word(a);
                if (cur.we) begin
                    for (int b = 0; b < 8; b++) begin
                        if (cur.strb[b]) begin
                            w[8*b +: 8] = cur.wdata[8*b +: 8];
                        end
                    end
                    mem[a] = w;
                end
                mem_rsp_i.valid <= 1'b1;
                mem_rsp_i.rdata <= cur.we ? 64'd0 : w;
            end
        end
        rdy = ($urandom % 3) != 0;
        mem_ready_i <= rdy;
        // transfer happens at the coming rising edge
        if (!outstanding && mem_req_o.valid && rdy) begin
            cur         = mem_req_o;
            outstanding = 1'b1;
            delay       = 1 + $urandom % 4;
            if (cur.we) begin
                bus_wr++;
                last_wr = cur;
            end else begin
                bus_rd++;
            end
        end
    end

    // responses follow the falling-edge memory update, so look a little later
    always @(negedge clk) begin
        #1;
        if (lsu_rsp_o.valid) lsu_seen++;
        if (fetch_rsp_o.valid) fetch_seen++;
    end

    // ********************************************************************
    // compare tasks
    // ********************************************************************
    task automatic check_lsu_rsp(input lsu_rsp_t exp, input lsu_rsp_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch lsu_rsp_o exp %h act %h", exp, act);
        end
    endtask

    task automatic check_fetch_rsp(input fetch_rsp_t exp, input fetch_rsp_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch fetch_rsp_o exp %h act %h", exp, act);
        end
    endtask

    task automatic check_mem_req(input mem_req_t exp, input mem_req_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch mem_req_o exp %h act %h", exp, act);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        if (!cond) begin
            errors++;
            $display("%s", what);
        end
    endtask

    task automatic check_idle();
        check_true(!lsu_rsp_o.valid && !fetch_rsp_o.valid && !mem_req_o.valid &&
                   lsu_ready_o && fetch_ready_o, "outputs not idle around reset");
    endtask

    // ********************************************************************
    // one load or store, returns latency in cycles after acceptance
    // ********************************************************************
    task automatic lsu_op(input logic we, input logic [31:0] addr, input mem_width_e w,
                          input logic sgn, input logic [63:0] wd, output int lat);
        lsu_rsp_t    exp;
        mem_req_t    exp_wr;
        mem_req_t    act_wr;
        logic [31:0] a;
        logic [63:0] sw;
        int          nb;
        int          off;
        nb  = 1 << w;
        off = addr[2:0];
        a   = {addr[31:3], 3'b000};
        do begin
            @(negedge clk);
        end while (!lsu_ready_o);
        lsu_req_i = '{valid: 1'b1, we: we, addr: addr, wdata: wd, width: w, sign: sgn};
        @(negedge clk);
        lsu_req_i.valid = 1'b0;
        lat = 1;
        #1;
        while (!lsu_rsp_o.valid) begin
            @(negedge clk);
            #1;
            lat++;
        end
        sw           = shadow_word(a);
        exp          = '0;
        exp.valid    = 1'b1;
        exp.is_write = we;
        if (!we) exp.rdata = extend(sw >> (8 * off), nb, sgn);
        check_lsu_rsp(exp, lsu_rsp_o);
        if (we) begin
            for (int k = 0; k < nb; k++) begin
                sw[8*(off+k) +: 8] = wd[8*k +: 8];
            end
            shadow[a]    = sw;
            exp_wr       = '0;
            exp_wr.valid = 1'b1;
            exp_wr.we    = 1'b1;
            exp_wr.addr  = a;
            exp_wr.strb  = ((8'd1 << nb) - 8'd1) << off;
            act_wr       = last_wr;
            // only strobed lanes carry data
            for (int b = 0; b < 8; b++) begin
                if (exp_wr.strb[b]) exp_wr.wdata[8*b +: 8] = sw[8*b +: 8];
                if (!act_wr.strb[b]) act_wr.wdata[8*b +: 8] = 8'h00;
            end
            check_mem_req(exp_wr, act_wr);
        end
        lsu_ops++;
    endtask

    task automatic fetch_op(input logic [31:0] addr);
        fetch_rsp_t exp;
        do begin
            @(negedge clk);
        end while (!fetch_ready_o);
        fetch_req_i.valid = 1'b1;
        fetch_req_i.addr  = addr;
        @(negedge clk);
        fetch_req_i.valid = 1'b0;
        #1;
        while (!fetch_rsp_o.valid) begin
            @(negedge clk);
            #1;
        end
        exp.valid = 1'b1;
        exp.data  = shadow_word(addr);
        check_fetch_rsp(exp, fetch_rsp_o);
        fetch_ops++;
    endtask

    task automatic end_test(input string name, input int err0);
        $display("%s: %s", name, (errors == err0) ? "ok" : "failed");
    endtask

    initial begin
        int          e0;
        int          lat;
        int          rd0;
        int          wr0;
        mem_width_e  w;
        logic [31:0] a;
        void'($urandom(32'h7457_b984));
        rst_n_i     = 1'b0;
        lsu_req_i   = '0;
        fetch_req_i = '0;
        mem_ready_i <= 1'b0;
        mem_rsp_i   <= '0;
        last_wr     = '0;
        outstanding = 1'b0;

        e0 = errors;
        repeat (16) begin
            @(negedge clk);
            check_idle();
        end
        rst_n_i = 1'b1;
        @(negedge clk);
        check_idle();
        end_test("reset state", e0);

        e0 = errors;
        repeat (24) begin
            w   = mem_width_e'($urandom % 4);
            a   = rand_addr(32'h1000_0000, 64, 1 << w);
            rd0 = bus_rd;
            wr0 = bus_wr;
            lsu_op(1'b0, a, w, 1'($urandom % 2), 64'd0, lat);
            check_true(bus_rd == rd0 + 1 && bus_wr == wr0, "uncached load bus count wrong");
        end
        end_test("uncached loads", e0);

        e0 = errors;
        repeat (16) begin
            w = mem_width_e'($urandom % 4);
            a = rand_addr(32'h8000_0000 + 32'h100 * ($urandom % 4), 16, 1 << w);
            lsu_op(1'b0, a, w, 1'($urandom % 2), 64'd0, lat);
            rd0 = bus_rd;
            lsu_op(1'b0, a, w, 1'($urandom % 2), 64'd0, lat);
            check_true(lat == 2, "cache hit did not answer in 2 cycles");
            check_true(bus_rd == rd0, "cache hit went to the bus");
        end
        end_test("cache hits", e0);

        e0 = errors;
        repeat (40) begin
            w   = mem_width_e'($urandom % 4);
            a   = rand_addr(($urandom % 2) ? 32'h8000_0000 : 32'h1000_0000, 8, 1 << w);
            rd0 = bus_rd;
            wr0 = bus_wr;
            lsu_op(1'b1, a, w, 1'b0, {$urandom, $urandom}, lat);
            check_true(bus_wr == wr0 + 1 && bus_rd == rd0, "store bus count wrong");
            w = mem_width_e'($urandom % 4);
            a = rand_addr(($urandom % 2) ? 32'h8000_0000 : 32'h1000_0000, 8, 1 << w);
            lsu_op(1'b0, a, w, 1'($urandom % 2), 64'd0, lat);
        end
        end_test("stores and merged loads", e0);

        e0 = errors;
        @(negedge clk);
        lsu_ops   = 0;
        fetch_ops = 0;
        lsu_seen  = 0;
        fetch_seen = 0;
        fork
            repeat (80) begin
                w = mem_width_e'($urandom % 4);
                a = rand_addr(($urandom % 2) ? 32'h8000_0000 : 32'h1000_0000, 8, 1 << w);
                lsu_op(1'($urandom % 2), a, w, 1'($urandom % 2), {$urandom, $urandom}, lat);
            end
            repeat (80) begin
                repeat ($urandom % 3) @(negedge clk);
                fetch_op(32'h0000_2000 + 8 * ($urandom % 32));
            end
        join
        @(negedge clk);
        check_true(lsu_seen == lsu_ops, "data responses lost or duplicated");
        check_true(fetch_seen == fetch_ops, "fetch responses lost or duplicated");
        end_test("concurrent fetch and data", e0);

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
